// ==== Bender.yml ====
package:
  name: alu_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/alu_pkg.sv
      - verilog/settleTimer.sv
      - verilog/addSubUnit.sv
      - verilog/logicUnit.sv
      - verilog/resultStage.sv
      - verilog/aluController.sv
      - verilog/aluTop.sv
      - target: test
        files:
          - tests/aluTop_assertions.sv
          - tests/aluTop_tb.sv

// ==== aluTop.f ====
+incdir+verilog
verilog/alu_pkg.sv
verilog/settleTimer.sv
verilog/addSubUnit.sv
verilog/logicUnit.sv
verilog/resultStage.sv
verilog/aluController.sv
verilog/aluTop.sv
tests/aluTop_assertions.sv
tests/aluTop_tb.sv

// ==== tests/aluTop_assertions.sv ====
`timescale 1ns/1ps

module aluTop_assertions (
  input logic clk,
  input logic rstN,
  input logic start,
  input logic busy,
  input logic done
);

  // high from an accepted start until its done
  logic pending;
  int   failCount = 0;

  // busy is low only in idle, so start with busy low is an accepted start
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pending <= 1'b0;
    end else if (start && !busy) begin
      pending <= 1'b1;
    end else if (done) begin
      pending <= 1'b0;
    end
  end

  // ----------------------------------------
  // protocol rules
  // ----------------------------------------
  doneOneCycle: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
    else begin
      failCount++;
      $error("done lasted more than one cycle");
    end

  busyFallsWithDone: assert property (@(posedge clk) disable iff (!rstN) $fell(busy) |-> done)
    else begin
      failCount++;
      $error("busy fell without done");
    end

  doneNeedsStart: assert property (@(posedge clk) disable iff (!rstN) done |-> pending)
    else begin
      failCount++;
      $error("done without an accepted start");
    end

endmodule

// ==== tests/aluTop_tb.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluTop_tb;

  import alu_pkg::*;

  localparam int clkPeriod   = 40;
  // start sampled at edge N, done seen after edge N+latency
  localparam int latency     = `ALU_SETTLE_CYCLES + 2;
  localparam int cyclesPerOp = `ALU_SETTLE_CYCLES + 4;
  // 88 add/sub, 32 logic, 8 slt, 2 zero, 2 for the ignored start, rounded up
  localparam int numOps      = 140;
  localparam int watchdogNs  = numOps * cyclesPerOp * clkPeriod * 2;

  logic        clk;
  logic        rstN;
  logic        start;
  aluReq_t     req;
  logic        busy;
  logic        done;
  aluRsp_t     rsp;
  logic [31:0] rngState;

  aluTop dut_i (
    .clk   (clk),
    .rstN  (rstN),
    .start (start),
    .req   (req),
    .busy  (busy),
    .done  (done),
    .rsp   (rsp)
  );

  bind aluTop aluTop_assertions assertions_i (
    .clk   (clk),
    .rstN  (rstN),
    .start (start),
    .busy  (busy),
    .done  (done)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // ends a hung run
  initial begin
    #(watchdogNs);
    failRun($sformatf("timeout: the tests did not finish within %0d ns", watchdogNs));
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic checkEqual(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
    if (actual !== expected) begin
      failRun($sformatf("error @ %0d ns: %s is %h, expected %h",
                        $time, what, actual, expected));
    end
  endtask

  // xorshift32
  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // expected response, 33-bit sums and signed compare
  function automatic aluRsp_t modelRsp(input aluReq_t r);
    aluRsp_t               m;
    logic [`ALU_WIDTH:0]   wide;
    logic [`ALU_WIDTH-1:0] a;
    logic [`ALU_WIDTH-1:0] b;
    m = '0;
    a = r.operandA;
    b = r.operandB;
    case (r.op)
      opAdd: begin
        wide = {1'b0, a} + {1'b0, b};
        m.result   = wide[`ALU_WIDTH-1:0];
        m.carryout = wide[`ALU_WIDTH];
        m.overflow = (a[`ALU_WIDTH-1] == b[`ALU_WIDTH-1]) &&
                     (wide[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
      end
      opSub: begin
        // a + ~b + 1, carry set when there is no borrow
        wide = {1'b0, a} + {1'b0, ~b} + 1'b1;
        m.result   = wide[`ALU_WIDTH-1:0];
        m.carryout = wide[`ALU_WIDTH];
        m.overflow = (a[`ALU_WIDTH-1] != b[`ALU_WIDTH-1]) &&
                     (wide[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
      end
      opSlt:   m.result = ($signed(a) < $signed(b)) ? 1 : 0;
      opXor:   m.result = a ^ b;
      opXnor:  m.result = ~(a ^ b);
      opNand:  m.result = ~(a & b);
      opNor:   m.result = ~(a | b);
      default: m.result = '0;
    endcase
    m.zero = (m.result == '0);
    return m;
  endfunction

  // one operation, optionally with a second start pulsed after injectAt cycles
  task automatic runOp(input aluReq_t r, input int injectAt, input aluReq_t other,
                       output aluRsp_t got, output int cycles);
    bit seen;
    seen = 1'b0;
    @(posedge clk);
    start <= 1'b1;
    req   <= r;
    // edge N, start sampled in idle
    @(posedge clk);
    start <= 1'b0;
    // cycles holds k while looking after edge N+k
    cycles = 0;
    while (!seen) begin
      @(negedge clk);
      if (done) begin
        seen = 1'b1;
      end else if (cycles >= cyclesPerOp) begin
        failRun($sformatf("no done within %0d cycles of an accepted start", cyclesPerOp));
      end else begin
        @(posedge clk);
        cycles++;
        start <= (cycles == injectAt);
        if (cycles == injectAt) begin
          req <= other;
        end
      end
    end
    got = rsp;
    checkEqual(busy, 1'b0, "busy in the done cycle");
  endtask

  task automatic compareRsp(input aluRsp_t got, input aluRsp_t exp, input string tag);
    checkEqual(got.result, exp.result, {tag, " result"});
    checkEqual(got.carryout, exp.carryout, {tag, " carryout"});
    checkEqual(got.overflow, exp.overflow, {tag, " overflow"});
    checkEqual(got.zero, exp.zero, {tag, " zero"});
  endtask

  task automatic checkOp(input aluOp_e op, input logic [`ALU_WIDTH-1:0] a,
                         input logic [`ALU_WIDTH-1:0] b, output aluRsp_t got);
    aluReq_t r;
    int      cycles;
    r.op       = op;
    r.operandA = a;
    r.operandB = b;
    runOp(r, 0, r, got, cycles);
    checkEqual(cycles, latency, {op.name(), " latency"});
    compareRsp(got, modelRsp(r), op.name());
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic testReset();
    @(negedge clk);
    checkEqual(busy, 1'b0, "busy after reset");
    checkEqual(done, 1'b0, "done after reset");
    checkEqual(rsp, '0, "rsp after reset");
  endtask

  task automatic testAddSub();
    logic [31:0] aList [4] = '{32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000, 32'h1234_5678};
    logic [31:0] bList [4] = '{32'h0000_0001, 32'h0000_0001, 32'h0000_0001, 32'h1234_5678};
    logic [31:0] a;
    logic [31:0] b;
    aluRsp_t     got;
    for (int i = 0; i < 4; i++) begin
      checkOp(opAdd, aList[i], bList[i], got);
      checkOp(opSub, aList[i], bList[i], got);
    end
    // random pairs
    for (int i = 0; i < 40; i++) begin
      a = nextRand();
      b = nextRand();
      checkOp(opAdd, a, b, got);
      checkOp(opSub, a, b, got);
    end
  endtask

  task automatic testLogic();
    aluOp_e      ops [4]   = '{opXor, opXnor, opNand, opNor};
    logic [31:0] aList [4] = '{32'h0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0};
    logic [31:0] bList [4] = '{32'h0, 32'hFFFF_FFFF, 32'h0, 32'hFFFF_FFFF};
    aluRsp_t     got;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 4; i++) begin
        checkOp(ops[k], aList[i], bList[i], got);
      end
      repeat (4) checkOp(ops[k], nextRand(), nextRand(), got);
    end
  endtask

  task automatic testSlt();
    // sign mix, equal, and pairs whose a-b overflows
    logic [31:0] aList [8] = '{32'hFFFF_FFFF, 32'h1, 32'h5, 32'h8000_0000,
                               32'h1, 32'h7FFF_FFFF, 32'h8000_0000, 32'h0};
    logic [31:0] bList [8] = '{32'h1, 32'hFFFF_FFFF, 32'h5, 32'h1,
                               32'h8000_0000, 32'h8000_0000, 32'h7FFF_FFFF, 32'h0};
    aluRsp_t     got;
    for (int i = 0; i < 8; i++) begin
      checkOp(opSlt, aList[i], bList[i], got);
    end
  endtask

  task automatic testIgnoredStart();
    aluReq_t first;
    aluReq_t second;
    aluRsp_t got;
    int      cycles;
    first.op        = opAdd;
    first.operandA  = nextRand();
    first.operandB  = nextRand();
    second.op       = opXor;
    second.operandA = nextRand();
    second.operandB = nextRand();
    runOp(first, 10, second, got, cycles);
    checkEqual(cycles, latency, "latency with a second start");
    compareRsp(got, modelRsp(first), "first request");
    // no second operation may follow
    repeat (cyclesPerOp) begin
      @(negedge clk);
      checkEqual(done, 1'b0, "done after the ignored start");
      checkEqual(busy, 1'b0, "busy after the ignored start");
    end
  endtask

  task automatic testZeroFlag();
    logic [31:0] v;
    aluRsp_t     got;
    v = nextRand();
    checkOp(opSub, v, v, got);
    checkEqual(got.zero, 1'b1, "zero for sub of equal operands");
    checkOp(opXor, v, v, got);
    checkEqual(got.zero, 1'b1, "zero for xor of equal operands");
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    rngState = 32'd13;
    rstN     = 1'b0;
    start    = 1'b0;
    req      = '0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    testReset();
    testAddSub();
    testLogic();
    testSlt();
    testIgnoredStart();
    testZeroFlag();
    if (dut_i.assertions_i.failCount != 0) begin
      failRun($sformatf("%0d protocol assertions failed", dut_i.assertions_i.failCount));
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// ==== verilog/addSubUnit.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module addSubUnit (
  input  alu_pkg::aluReq_t         curReq,
  output logic [`ALU_WIDTH-1:0]    sum,
  output logic                     carryout,
  output logic                     overflow
);

  import alu_pkg::*;

  wire                  opHiN;
  wire                  subtract;
  wire [`ALU_WIDTH-1:0] bEff;
  wire [`ALU_WIDTH-1:0] prop;
  wire [`ALU_WIDTH-1:0] gen;
  wire [`ALU_WIDTH-1:0] carryProp;
  wire [`ALU_WIDTH-1:0] sumW;
  wire [`ALU_WIDTH:0]   carry;
  wire                  overflowW;

  // ----------------------------------------
  // subtract decode
  // ----------------------------------------
  // high for opSub and opSlt, i.e. op[2] low and op[0] high
  not #(`ALU_DLY_NOT) opHiInv (opHiN, curReq.op[2]);
  and #(`ALU_DLY_AND) subDecode (subtract, opHiN, curReq.op[0]);

  // subtract bit doubles as carry-in, giving A + ~B + 1
  assign carry[0] = subtract;

  // ----------------------------------------
  // ripple-carry slices
  // ----------------------------------------
  for (genvar i = 0; i < `ALU_WIDTH; i++) begin : slice
    // conditional invert of B
    xor #(`ALU_DLY_XOR) bInv (bEff[i], curReq.operandB[i], subtract);
    // full adder, sum = a ^ b ^ cin
    xor #(`ALU_DLY_XOR) propGate (prop[i], curReq.operandA[i], bEff[i]);
    xor #(`ALU_DLY_XOR) sumGate (sumW[i], prop[i], carry[i]);
    // cout = a&b | (a^b)&cin
    and #(`ALU_DLY_AND) genGate (gen[i], curReq.operandA[i], bEff[i]);
    and #(`ALU_DLY_AND) carryAnd (carryProp[i], prop[i], carry[i]);
    or  #(`ALU_DLY_OR)  carryOr (carry[i+1], gen[i], carryProp[i]);
  end

  // signed overflow when carry into and out of the msb differ
  xor #(`ALU_DLY_XOR) ovfGate (overflowW, carry[`ALU_WIDTH], carry[`ALU_WIDTH-1]);

  assign sum      = sumW;
  assign carryout = carry[`ALU_WIDTH];
  assign overflow = overflowW;

endmodule

// ==== verilog/aluController.sv ====
`timescale 1ns/1ps

module aluController (
  input  logic              clk,
  input  logic              rstN,
  input  logic              start,
  input  alu_pkg::aluReq_t  req,
  input  logic              expired,
  output logic              timerLoad,
  output logic              capture,
  output alu_pkg::aluReq_t  curReq,
  output logic              busy,
  output logic              done
);

  import alu_pkg::*;

  aluState_e state;
  aluState_e stateNext;

  // a start only counts when sampled in idle
  assign timerLoad = (state == stIdle) && start;
  assign capture   = (state == stCapture);
  assign busy      = (state != stIdle);

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    stateNext = state;
    case (state)
      stIdle:    if (start) stateNext = stSettle;
      // wait until the gate outputs have rippled through
      stSettle:  if (expired) stateNext = stCapture;
      stCapture: stateNext = stIdle;
      default:   stateNext = stIdle;
    endcase
  end

  // state and done pulse
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= stIdle;
      done  <= 1'b0;
    end else begin
      state <= stateNext;
      // done rises on the same edge the result stage captures
      done  <= (state == stCapture);
    end
  end

  // request held steady for the whole settle window
  always_ff @(posedge clk) begin
    if (timerLoad) begin
      curReq <= req;
    end
  end

endmodule

// ==== verilog/aluTop.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluTop (
  input  logic              clk,
  input  logic              rstN,
  input  logic              start,
  input  alu_pkg::aluReq_t  req,
  output logic              busy,
  output logic              done,
  output alu_pkg::aluRsp_t  rsp
);

  import alu_pkg::*;

  aluReq_t               curReq;
  logic                  timerLoad;
  logic                  expired;
  logic                  capture;
  logic [`ALU_WIDTH-1:0] sum;
  logic                  carryout;
  logic                  overflow;
  logic [`ALU_WIDTH-1:0] logicResult;

  // ----------------------------------------
  // control
  // ----------------------------------------
  aluController ctrl_i (
    .clk       (clk),
    .rstN      (rstN),
    .start     (start),
    .req       (req),
    .expired   (expired),
    .timerLoad (timerLoad),
    .capture   (capture),
    .curReq    (curReq),
    .busy      (busy),
    .done      (done)
  );

  settleTimer timer_i (
    .clk     (clk),
    .rstN    (rstN),
    .load    (timerLoad),
    .expired (expired)
  );

  // ----------------------------------------
  // gate datapath and capture
  // ----------------------------------------
  addSubUnit addSub_i (
    .curReq   (curReq),
    .sum      (sum),
    .carryout (carryout),
    .overflow (overflow)
  );

  logicUnit logic_i (
    .curReq      (curReq),
    .logicResult (logicResult)
  );

  resultStage result_i (
    .clk         (clk),
    .rstN        (rstN),
    .capture     (capture),
    .curReq      (curReq),
    .sum         (sum),
    .carryout    (carryout),
    .overflow    (overflow),
    .logicResult (logicResult),
    .rsp         (rsp)
  );

endmodule

// ==== verilog/alu_defines.svh ====
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// operand and result width
`define ALU_WIDTH 32

// clock cycles the gate datapath gets before the result is sampled
// 64 cycles at 40 ns cover the worst carry ripple with some margin
`define ALU_SETTLE_CYCLES 64
// settle counter width, must hold ALU_SETTLE_CYCLES
`define ALU_TIMER_WIDTH 7

// ----------------------------------------
// primitive gate delays, in ns
// ----------------------------------------
`define ALU_DLY_NOT 10
`define ALU_DLY_NAND 20
`define ALU_DLY_AND 30
`define ALU_DLY_NOR 20
`define ALU_DLY_OR 30
`define ALU_DLY_XNOR 50
`define ALU_DLY_XOR 50

`endif

// ==== verilog/alu_pkg.sv ====
`include "alu_defines.svh"

package alu_pkg;

  // opcode encoding
  // op[2] low with op[0] high marks the two subtracting ops
  typedef enum logic [2:0] {
    opAdd  = 3'b000,
    opSub  = 3'b001,
    opSlt  = 3'b011,
    opXor  = 3'b100,
    opXnor = 3'b101,
    opNand = 3'b110,
    opNor  = 3'b111
  } aluOp_e;

  // controller states
  typedef enum logic [1:0] {
    stIdle,
    stSettle,
    stCapture
  } aluState_e;

  // request as seen at the top and latched by the controller
  typedef struct packed {
    aluOp_e                  op;
    logic [`ALU_WIDTH-1:0]   operandA;
    logic [`ALU_WIDTH-1:0]   operandB;
  } aluReq_t;

  // registered response
  typedef struct packed {
    logic [`ALU_WIDTH-1:0]   result;
    logic                    carryout;
    logic                    overflow;
    logic                    zero;
  } aluRsp_t;

endpackage

// ==== verilog/logicUnit.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module logicUnit (
  input  alu_pkg::aluReq_t         curReq,
  output logic [`ALU_WIDTH-1:0]    logicResult
);

  import alu_pkg::*;

  wire [`ALU_WIDTH-1:0] xorRes;
  wire [`ALU_WIDTH-1:0] xnorRes;
  wire [`ALU_WIDTH-1:0] nandRes;
  wire [`ALU_WIDTH-1:0] norRes;

  // ----------------------------------------
  // bitwise gate arrays
  // ----------------------------------------
  // all four run in parallel on the same operands
  for (genvar i = 0; i < `ALU_WIDTH; i++) begin : bitGates
    xor  #(`ALU_DLY_XOR)  xorGate (xorRes[i], curReq.operandA[i], curReq.operandB[i]);
    xnor #(`ALU_DLY_XNOR) xnorGate (xnorRes[i], curReq.operandA[i], curReq.operandB[i]);
    nand #(`ALU_DLY_NAND) nandGate (nandRes[i], curReq.operandA[i], curReq.operandB[i]);
    nor  #(`ALU_DLY_NOR)  norGate (norRes[i], curReq.operandA[i], curReq.operandB[i]);
  end

  // ----------------------------------------
  // opcode select
  // ----------------------------------------
  always_comb begin
    case (curReq.op)
      opXor:   logicResult = xorRes;
      opXnor:  logicResult = xnorRes;
      opNand:  logicResult = nandRes;
      opNor:   logicResult = norRes;
      // arithmetic ops take their result elsewhere
      default: logicResult = '0;
    endcase
  end

endmodule

// ==== verilog/resultStage.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module resultStage (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     capture,
  input  alu_pkg::aluReq_t         curReq,
  input  logic [`ALU_WIDTH-1:0]    sum,
  input  logic                     carryout,
  input  logic                     overflow,
  input  logic [`ALU_WIDTH-1:0]    logicResult,
  output alu_pkg::aluRsp_t         rsp
);

  import alu_pkg::*;

  aluRsp_t rspNext;

  // ----------------------------------------
  // result and flag select
  // ----------------------------------------
  always_comb begin
    rspNext = '0;
    case (curReq.op)
      opAdd, opSub: begin
        rspNext.result   = sum;
        // flags only mean something for add and sub
        rspNext.carryout = carryout;
        rspNext.overflow = overflow;
      end
      opSlt: begin
        // sign of a-b, corrected when the subtraction overflows
        rspNext.result[0] = sum[`ALU_WIDTH-1] ^ overflow;
      end
      default: begin
        rspNext.result = logicResult;
      end
    endcase
    rspNext.zero = (rspNext.result == '0);
  end

  // response holds until the next capture
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rsp <= '0;
    end else if (capture) begin
      rsp <= rspNext;
    end
  end

endmodule

// ==== verilog/settleTimer.sv ====
`timescale 1ns/1ps
`include "alu_defines.svh"

module settleTimer (
  input  logic clk,
  input  logic rstN,
  input  logic load,
  output logic expired
);

  logic [`ALU_TIMER_WIDTH-1:0] count;

  // ----------------------------------------
  // saturating down-counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN) begin
      count <= '0;
    end else if (load) begin
      count <= `ALU_TIMER_WIDTH'(`ALU_SETTLE_CYCLES);
    end else if (count != '0) begin
      // one step per edge, parks at zero
      count <= count - 1'b1;
    end
  end

  // level, stays high while parked at zero
  assign expired = (count == '0);

endmodule
